// ==== boot_rom.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o
);

  localparam int unsigned RomWords = 16;

  // Boot table
  localparam soc_pkg::data_t RomTable [RomWords] = '{
    64'h0000_0297_f140_2573, 64'h0182_b283_0202_8593,
    64'h0000_0513_0000_0593, 64'h1050_0073_ffdf_f06f,
    64'h8000_0000_0000_0000, 64'h0000_0000_8000_2000,
    64'h0200_0000_0000_c000, 64'h0000_0001_0000_0002,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5a5a_5a5a_a5a5_a5a5,
    64'h0000_0010_0000_0020, 64'h1111_2222_3333_4444,
    64'h7fff_ffff_8000_0001, 64'h0000_0000_0000_0073
  };

  soc_pkg::addr_t rom_ofs;
  logic           in_table;
  logic           rvalid_q;
  soc_pkg::data_t rdata_q;

  assign rom_ofs  = req_i.addr - `ROM_BASE;
  assign in_table = rom_ofs < soc_pkg::addr_t'(RomWords * 8);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Writes only get the acknowledge
  always_ff @(posedge clk_i) begin : p_rdata
    if (req_i.req) begin
      rdata_q <= (!req_i.we && in_table) ? RomTable[req_i.addr[6:3]] : '0;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// ==== clint.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module clint (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rtc_i,
  input  soc_pkg::mem_req_t  req_i,
  output soc_pkg::mem_rsp_t  rsp_o,
  output soc_pkg::hart_vec_t timer_irq_o,
  output soc_pkg::hart_vec_t ipi_o
);

  localparam int unsigned NumHarts = `NUM_HARTS;
  localparam int unsigned CmpWord  = `MTIMECMP_OFS / 8;
  localparam int unsigned TimeWord = `MTIME_OFS / 8;

  logic [15:0]        reg_ofs;
  logic [12:0]        word_idx;
  logic               wr_en;
  logic [1:0]         rtc_sync_q;
  logic               rtc_prev_q;
  logic               rtc_tick;
  soc_pkg::data_t     mtime_q;
  soc_pkg::data_t     mtimecmp_q [NumHarts];
  soc_pkg::hart_vec_t msip_q;
  soc_pkg::hart_vec_t timer_irq_q;
  soc_pkg::data_t     rd_data;
  soc_pkg::data_t     rdata_q;
  logic               rvalid_q;

  // The whole CLINT window fits in 16 offset bits
  assign reg_ofs  = 16'(req_i.addr - `CLINT_BASE);
  assign word_idx = reg_ofs[15:3];
  assign wr_en    = req_i.req & req_i.we;

  // Rising edge of the synchronised RTC
  assign rtc_tick = rtc_sync_q[1] & ~rtc_prev_q;

  // --------------------
  // Register read
  // --------------------

  always_comb begin : p_read
    rd_data = '0;
    if (word_idx == 13'(TimeWord)) begin
      rd_data = mtime_q;
    end
    for (int h = 0; h < NumHarts; h++) begin
      if (word_idx == 13'(h)) begin
        rd_data = {63'b0, msip_q[h]};
      end
      if (word_idx == 13'(CmpWord + h)) begin
        rd_data = mtimecmp_q[h];
      end
    end
  end

  // --------------------
  // Timer and registers
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rtc_sync_q  <= '0;
      rtc_prev_q  <= 1'b0;
      mtime_q     <= '0;
      msip_q      <= '0;
      timer_irq_q <= '0;
      rvalid_q    <= 1'b0;
      for (int h = 0; h < NumHarts; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      rvalid_q   <= req_i.req;
      // A software write to mtime wins over the tick
      if (wr_en && (word_idx == 13'(TimeWord))) begin
        mtime_q <= soc_pkg::merge_be(mtime_q, req_i.wdata, req_i.be);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      for (int h = 0; h < NumHarts; h++) begin
        if (wr_en && (word_idx == 13'(h)) && req_i.be[0]) begin
          msip_q[h] <= req_i.wdata[0];
        end
        if (wr_en && (word_idx == 13'(CmpWord + h))) begin
          mtimecmp_q[h] <= soc_pkg::merge_be(mtimecmp_q[h], req_i.wdata, req_i.be);
        end
        timer_irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rd_data;
    end
  end

  assign rsp_o       = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

// ==== debug_reset_ctrl.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module debug_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_en_i,
  input  logic debug_req_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(`DMI_DEL_CYCLES + 1);

  typedef logic [CntWidth-1:0] del_cnt_t;

  logic       comb_rst_n;
  logic [1:0] rst_sync_q;
  del_cnt_t   del_cnt_q;

  // --------------------
  // System reset
  // --------------------

  // Power-on reset or debug-module reset request
  assign comb_rst_n = rst_ni & ~ndmreset_i;

  // Asserts at once, releases on the second clock edge
  always_ff @(posedge clk_i or negedge comb_rst_n) begin : p_rst_sync
    if (!comb_rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = rst_sync_q[1];

  // --------------------
  // Debug request gate
  // --------------------

  // Boot window, only power-on reset reloads it
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_del_cnt
    if (!rst_ni) begin
      del_cnt_q <= del_cnt_t'(`DMI_DEL_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (del_cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

// ==== dram_ctrl.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module dram_ctrl #(
  parameter int unsigned NUM_WORDS = `DRAM_WORDS
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output soc_pkg::data_t    exit_o
);

  localparam int unsigned IdxWidth = $clog2(NUM_WORDS);

  soc_pkg::data_t      mem_q [NUM_WORDS];
  soc_pkg::addr_t      dram_ofs;
  logic [IdxWidth-1:0] word_idx;
  logic                rvalid_q;
  soc_pkg::data_t      rdata_q;

  // Byte offset into DRAM, eight bytes per word
  assign dram_ofs = req_i.addr - `DRAM_BASE;
  assign word_idx = dram_ofs[IdxWidth+2:3];

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk_i) begin : p_mem
    if (req_i.req) begin
      if (req_i.we) begin
        mem_q[word_idx] <= soc_pkg::merge_be(mem_q[word_idx], req_i.wdata, req_i.be);
        rdata_q         <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

  // --------------------
  // Exit word
  // --------------------

  // Seen in the same cycle as the write, low address bits ignored
  assign exit_o = (req_i.req && req_i.we && ({req_i.addr[31:3], 3'b000} == `EXIT_ADDR))
                  ? req_i.wdata : '0;

endmodule

// ==== filelist.f ====
+incdir+.
soc_pkg.sv
debug_reset_ctrl.sv
soc_xbar.sv
boot_rom.sv
dram_ctrl.sv
clint.sv
soc_top.sv
tb_soc.sv

// ==== soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// --------------------
// System size
// --------------------

`define NUM_HARTS 2

// --------------------
// Address map
// --------------------

// Boot ROM window
`define ROM_BASE 32'h0001_0000
`define ROM_LEN 32'h0001_0000

// Core-local interruptor
`define CLINT_BASE 32'h0200_0000
`define CLINT_LEN 32'h0000_C000

// GPIO window, no device behind it
`define GPIO_BASE 32'h4000_0000
`define GPIO_LEN 32'h0000_1000

// Main memory, 64-bit words
`define DRAM_BASE 32'h8000_0000
`define DRAM_WORDS 1024

// Harness exit word, inside DRAM
`define EXIT_ADDR 32'h8000_1000

// CLINT register offsets
`define MTIMECMP_OFS 32'h0000_4000
`define MTIME_OFS 32'h0000_BFF8

// Cycles after power-on before debug requests pass
`define DMI_DEL_CYCLES 500

`endif

// ==== soc_pkg.sv ====
`include "soc_params.svh"

package soc_pkg;

  // --------------------
  // Basic vectors
  // --------------------

  typedef logic [31:0]            addr_t;
  typedef logic [63:0]            data_t;
  typedef logic [7:0]             strb_t;
  typedef logic [`NUM_HARTS-1:0]  hart_vec_t;

  // --------------------
  // Memory bus
  // --------------------

  // One request per cycle while req is high
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } mem_req_t;

  // Answer arrives exactly one cycle after the request
  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

  // Slave chosen by the crossbar decoder
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_ROM,
    SEL_DRAM,
    SEL_CLINT,
    SEL_GPIO,
    SEL_ERR
  } slv_sel_e;

  // Byte-lane merge of write data into an existing word
  function automatic data_t merge_be(data_t old_data, data_t new_data, strb_t be);
    data_t merged;
    merged = old_data;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== soc_top.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rtc_i,
  input  logic               ndmreset_i,
  input  logic               debug_en_i,
  input  logic               debug_req_i,
  input  soc_pkg::mem_req_t  bus_req_i,
  output soc_pkg::mem_rsp_t  bus_rsp_o,
  output soc_pkg::data_t     exit_o,
  output soc_pkg::hart_vec_t timer_irq_o,
  output soc_pkg::hart_vec_t ipi_o,
  output logic               debug_req_o
);

  logic              sys_rst_n;
  soc_pkg::mem_req_t rom_req;
  soc_pkg::mem_req_t dram_req;
  soc_pkg::mem_req_t clint_req;
  soc_pkg::mem_rsp_t rom_rsp;
  soc_pkg::mem_rsp_t dram_rsp;
  soc_pkg::mem_rsp_t clint_rsp;

  // --------------------
  // Reset and debug
  // --------------------

  debug_reset_ctrl i_debug_reset_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .sys_rst_no  ( sys_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------
  // Bus and slaves
  // --------------------

  soc_xbar i_soc_xbar (
    .clk_i       ( clk_i     ),
    .rst_ni      ( sys_rst_n ),
    .mst_req_i   ( bus_req_i ),
    .mst_rsp_o   ( bus_rsp_o ),
    .rom_req_o   ( rom_req   ),
    .dram_req_o  ( dram_req  ),
    .clint_req_o ( clint_req ),
    .rom_rsp_i   ( rom_rsp   ),
    .dram_rsp_i  ( dram_rsp  ),
    .clint_rsp_i ( clint_rsp )
  );

  boot_rom i_boot_rom (
    .clk_i  ( clk_i     ),
    .rst_ni ( sys_rst_n ),
    .req_i  ( rom_req   ),
    .rsp_o  ( rom_rsp   )
  );

  // Power-on reset only, contents survive a debug reset
  dram_ctrl #(
    .NUM_WORDS ( `DRAM_WORDS )
  ) i_dram_ctrl (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .req_i  ( dram_req ),
    .rsp_o  ( dram_rsp ),
    .exit_o ( exit_o   )
  );

  clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

// ==== soc_xbar.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_xbar (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::mem_req_t mst_req_i,
  output soc_pkg::mem_rsp_t mst_rsp_o,
  output soc_pkg::mem_req_t rom_req_o,
  output soc_pkg::mem_req_t dram_req_o,
  output soc_pkg::mem_req_t clint_req_o,
  input  soc_pkg::mem_rsp_t rom_rsp_i,
  input  soc_pkg::mem_rsp_t dram_rsp_i,
  input  soc_pkg::mem_rsp_t clint_rsp_i
);

  localparam soc_pkg::addr_t DramLen = soc_pkg::addr_t'(`DRAM_WORDS * 8);

  soc_pkg::slv_sel_e sel_d;
  soc_pkg::slv_sel_e sel_q;

  // Half-open window test, written to avoid overflow at the top of memory
  function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                     soc_pkg::addr_t len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  // --------------------
  // Address decode
  // --------------------

  always_comb begin : p_decode
    if (in_window(mst_req_i.addr, `ROM_BASE, `ROM_LEN)) begin
      sel_d = soc_pkg::SEL_ROM;
    end else if (in_window(mst_req_i.addr, `CLINT_BASE, `CLINT_LEN)) begin
      sel_d = soc_pkg::SEL_CLINT;
    end else if (in_window(mst_req_i.addr, `GPIO_BASE, `GPIO_LEN)) begin
      sel_d = soc_pkg::SEL_GPIO;
    end else if (in_window(mst_req_i.addr, `DRAM_BASE, DramLen)) begin
      sel_d = soc_pkg::SEL_DRAM;
    end else begin
      sel_d = soc_pkg::SEL_ERR;
    end
  end

  // Payload goes everywhere, only the strobe is steered
  always_comb begin : p_steer
    rom_req_o       = mst_req_i;
    dram_req_o      = mst_req_i;
    clint_req_o     = mst_req_i;
    rom_req_o.req   = mst_req_i.req && (sel_d == soc_pkg::SEL_ROM);
    dram_req_o.req  = mst_req_i.req && (sel_d == soc_pkg::SEL_DRAM);
    clint_req_o.req = mst_req_i.req && (sel_d == soc_pkg::SEL_CLINT);
  end

  // --------------------
  // Response path
  // --------------------

  // Remember which slave answers in the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sel
    if (!rst_ni) begin
      sel_q <= soc_pkg::SEL_NONE;
    end else begin
      sel_q <= mst_req_i.req ? sel_d : soc_pkg::SEL_NONE;
    end
  end

  always_comb begin : p_rsp_mux
    mst_rsp_o = '0;
    case (sel_q)
      soc_pkg::SEL_ROM:   mst_rsp_o = rom_rsp_i;
      soc_pkg::SEL_DRAM:  mst_rsp_o = dram_rsp_i;
      soc_pkg::SEL_CLINT: mst_rsp_o = clint_rsp_i;
      // GPIO and holes in the map both answer with an error
      soc_pkg::SEL_GPIO, soc_pkg::SEL_ERR: begin
        mst_rsp_o.rvalid = 1'b1;
        mst_rsp_o.err    = 1'b1;
      end
      default: begin
        mst_rsp_o = '0;
      end
    endcase
  end

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc;

  localparam int unsigned Timeout = 200;

  // One expected bus response and the cycle it is due in
  typedef struct packed {
    logic [31:0]       due;
    logic              mono;
    soc_pkg::mem_rsp_t rsp;
  } exp_t;

  logic               clk;
  logic               rst_n;
  logic               rtc;
  logic               ndmreset;
  logic               debug_en;
  logic               debug_req;
  soc_pkg::mem_req_t  bus_req;
  soc_pkg::mem_rsp_t  bus_rsp;
  soc_pkg::data_t     exit_word;
  soc_pkg::hart_vec_t timer_irq;
  soc_pkg::hart_vec_t ipi;
  logic               debug_req_out;

  logic [31:0]        cyc = '0;
  logic               cmp_en = 1'b0;
  exp_t               exp_q[$];
  soc_pkg::data_t     last_mtime = '0;
  soc_pkg::data_t     dram_shadow [`DRAM_WORDS];
  logic               dram_written [`DRAM_WORDS];
  soc_pkg::hart_vec_t msip_shadow;
  soc_pkg::data_t     cmp_shadow [`NUM_HARTS];

  // Boot table contents
  localparam soc_pkg::data_t RomCopy [16] = '{
    64'h0000_0297_f140_2573, 64'h0182_b283_0202_8593,
    64'h0000_0513_0000_0593, 64'h1050_0073_ffdf_f06f,
    64'h8000_0000_0000_0000, 64'h0000_0000_8000_2000,
    64'h0200_0000_0000_c000, 64'h0000_0001_0000_0002,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5a5a_5a5a_a5a5_a5a5,
    64'h0000_0010_0000_0020, 64'h1111_2222_3333_4444,
    64'h7fff_ffff_8000_0001, 64'h0000_0000_0000_0073
  };

  soc_top UUT (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .ndmreset_i  ( ndmreset      ),
    .debug_en_i  ( debug_en      ),
    .debug_req_i ( debug_req     ),
    .bus_req_i   ( bus_req       ),
    .bus_rsp_o   ( bus_rsp       ),
    .exit_o      ( exit_word     ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           ),
    .debug_req_o ( debug_req_out )
  );

  initial begin : p_clk
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin : p_cyc
    cyc <= cyc + 1;
  end

  // --------------------
  // Checks
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rsp(input string name, input soc_pkg::mem_rsp_t exp,
                           input soc_pkg::mem_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input soc_pkg::data_t exp,
                            input soc_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_harts(input string name, input soc_pkg::hart_vec_t exp,
                             input soc_pkg::hart_vec_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, act));
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  function automatic logic in_range(input soc_pkg::addr_t a, input soc_pkg::addr_t base,
                                    input soc_pkg::addr_t len);
    return (a >= base) && ((a - base) < len);
  endfunction

  function automatic soc_pkg::data_t apply_strobes(input soc_pkg::data_t old_word,
                                                   input soc_pkg::data_t new_word,
                                                   input soc_pkg::strb_t be);
    soc_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic soc_pkg::mem_rsp_t ref_read(input soc_pkg::addr_t addr);
    soc_pkg::mem_rsp_t rsp;
    soc_pkg::addr_t    a;
    soc_pkg::addr_t    ofs;
    a   = {addr[31:3], 3'b000};
    rsp = '{rvalid: 1'b1, err: 1'b0, rdata: '0};
    if (in_range(a, `ROM_BASE, `ROM_LEN)) begin
      ofs = a - `ROM_BASE;
      if (ofs < 32'd128) begin
        rsp.rdata = RomCopy[ofs[6:3]];
      end
    end else if (in_range(a, `CLINT_BASE, `CLINT_LEN)) begin
      ofs = a - `CLINT_BASE;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        if (ofs == 8 * h) begin
          rsp.rdata = {63'b0, msip_shadow[h]};
        end
        if (ofs == `MTIMECMP_OFS + 8 * h) begin
          rsp.rdata = cmp_shadow[h];
        end
      end
    end else if (in_range(a, `DRAM_BASE, `DRAM_WORDS * 8)) begin
      rsp.rdata = dram_shadow[(a - `DRAM_BASE) >> 3];
    end else begin
      // GPIO window and holes in the map
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  function automatic void apply_write(input soc_pkg::addr_t addr, input soc_pkg::strb_t be,
                                      input soc_pkg::data_t wdata);
    soc_pkg::addr_t a;
    soc_pkg::addr_t ofs;
    a = {addr[31:3], 3'b000};
    if (in_range(a, `DRAM_BASE, `DRAM_WORDS * 8)) begin
      ofs               = (a - `DRAM_BASE) >> 3;
      dram_shadow[ofs]  = apply_strobes(dram_shadow[ofs], wdata, be);
      dram_written[ofs] = 1'b1;
    end else if (in_range(a, `CLINT_BASE, `CLINT_LEN)) begin
      ofs = a - `CLINT_BASE;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        if ((ofs == 8 * h) && be[0]) begin
          msip_shadow[h] = wdata[0];
        end
        if (ofs == `MTIMECMP_OFS + 8 * h) begin
          cmp_shadow[h] = apply_strobes(cmp_shadow[h], wdata, be);
        end
      end
    end
  endfunction

  // Responses are due one cycle after their request
  always @(negedge clk) begin : p_compare
    exp_t e;
    if (cmp_en) begin
      if ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
        e = exp_q.pop_front();
        if (e.mono) begin
          if ((bus_rsp.rvalid !== 1'b1) || (bus_rsp.err !== 1'b0)) begin
            abort_run("mtime read was not answered with a valid response");
          end
          if ($isunknown(bus_rsp.rdata) || (bus_rsp.rdata < last_mtime)) begin
            abort_run($sformatf("** Error: mtime expected at least %h, got %h",
                                last_mtime, bus_rsp.rdata));
          end
          last_mtime = bus_rsp.rdata;
        end else begin
          check_rsp("bus_rsp_o", e.rsp, bus_rsp);
        end
      end else begin
        check_rsp("bus_rsp_o", '0, bus_rsp);
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  task automatic issue(input logic we, input soc_pkg::addr_t addr, input soc_pkg::strb_t be,
                       input soc_pkg::data_t wdata, input logic mono);
    exp_t           e;
    soc_pkg::data_t exit_exp;
    @(negedge clk);
    bus_req  = '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
    e.due    = cyc + 1;
    e.mono   = mono;
    e.rsp    = ref_read(addr);
    exit_exp = '0;
    if (we) begin
      e.rsp.rdata = '0;
      apply_write(addr, be, wdata);
      if ({addr[31:3], 3'b000} == `EXIT_ADDR) begin
        exit_exp = wdata;
      end
    end
    exp_q.push_back(e);
    #1;
    check_data("exit_o", exit_exp, exit_word);
  endtask

  task automatic write_word(input soc_pkg::addr_t addr, input soc_pkg::strb_t be,
                            input soc_pkg::data_t wdata);
    issue(1'b1, addr, be, wdata, 1'b0);
  endtask

  task automatic read_word(input soc_pkg::addr_t addr);
    issue(1'b0, addr, '0, '0, 1'b0);
  endtask

  task automatic read_mtime();
    issue(1'b0, `CLINT_BASE + `MTIME_OFS, '0, '0, 1'b1);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      bus_req = '0;
    end
  endtask

  // Toggles the RTC until the timer interrupt of hart h rises
  task automatic wait_timer(input int h);
    soc_pkg::hart_vec_t want;
    int                 n;
    want    = '0;
    want[h] = 1'b1;
    n       = 0;
    while (timer_irq[h] !== 1'b1) begin
      if (n == Timeout) begin
        abort_run($sformatf("timer interrupt of hart %0d did not rise in time", h));
      end
      @(negedge clk);
      if (n % 4 == 0) begin
        rtc = ~rtc;
      end
      check_harts("timer_irq_o", '0, timer_irq & ~want);
      n++;
    end
    check_harts("timer_irq_o", want, timer_irq);
  endtask

  initial begin : p_main
    soc_pkg::addr_t     cmp_addr;
    soc_pkg::strb_t     be;
    soc_pkg::hart_vec_t irq_exp;
    int                 n;
    int                 idx;
    void'($urandom(43231));
    rst_n       = 1'b0;
    rtc         = 1'b0;
    ndmreset    = 1'b0;
    debug_en    = 1'b1;
    debug_req   = 1'b1;
    bus_req     = '0;
    msip_shadow = '0;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      cmp_shadow[h] = '1;
    end
    for (int i = 0; i < `DRAM_WORDS; i++) begin
      dram_written[i] = 1'b0;
    end
    repeat (10) @(negedge clk);
    rst_n  = 1'b1;
    cmp_en = 1'b1;

    // Debug request held back during the boot window
    for (int i = 0; i < 490; i++) begin
      @(negedge clk);
      check_bit("debug_req_o", 1'b0, debug_req_out);
    end
    check_harts("timer_irq_o", '0, timer_irq);
    check_harts("ipi_o", '0, ipi);
    check_data("exit_o", '0, exit_word);
    n = 0;
    while (debug_req_out !== 1'b1) begin
      if (n == Timeout) begin
        abort_run("debug request was still blocked after the power-on delay");
      end
      @(negedge clk);
      n++;
    end
    debug_en = 1'b0;
    @(negedge clk);
    check_bit("debug_req_o", 1'b0, debug_req_out);
    debug_en  = 1'b1;
    debug_req = 1'b0;

    // ROM table and one word past it, then the error windows
    for (int i = 0; i <= 16; i++) begin
      read_word(`ROM_BASE + 8 * i);
    end
    write_word(`ROM_BASE, 8'hff, 64'h1234_5678);
    read_word(`ROM_BASE);
    read_word(`GPIO_BASE);
    write_word(`GPIO_BASE + 8, 8'hff, 64'h1);
    read_word(`GPIO_BASE + `GPIO_LEN - 8);
    read_word(32'h0000_0000);
    read_word(32'h1000_0000);
    read_word(`CLINT_BASE + `CLINT_LEN);
    write_word(`DRAM_BASE + `DRAM_WORDS * 8, 8'hff, '1);
    read_word(32'hffff_fff8);
    idle(2);

    // Random DRAM writes with full strobes on the first touch of a word
    for (int i = 0; i < 200; i++) begin
      idx = $urandom % 64;
      be  = dram_written[idx] ? soc_pkg::strb_t'($urandom) : 8'hff;
      write_word(`DRAM_BASE + 8 * idx, be, {$urandom, $urandom});
    end
    for (int i = 0; i < `DRAM_WORDS; i++) begin
      if (dram_written[i]) begin
        read_word(`DRAM_BASE + 8 * i);
      end
    end
    idle(2);

    // Exit word
    write_word(`EXIT_ADDR, 8'hff, 64'h0000_0000_0000_0001);
    write_word(`EXIT_ADDR + 8, 8'hff, 64'hffff_0000_1234_5678);
    write_word(`EXIT_ADDR, 8'hff, {$urandom, $urandom});
    read_word(`EXIT_ADDR);
    idle(2);

    // Software interrupt of each hart, then a write with be[0] clear
    for (int h = 0; h < `NUM_HARTS; h++) begin
      write_word(`CLINT_BASE + 8 * h, 8'h01, 64'h1);
      idle(2);
      check_harts("ipi_o", msip_shadow, ipi);
    end
    write_word(`CLINT_BASE, 8'h02, 64'h0);
    idle(2);
    check_harts("ipi_o", msip_shadow, ipi);
    write_word(`CLINT_BASE, 8'h01, 64'h0);
    read_word(`CLINT_BASE);
    read_word(`CLINT_BASE + 8);
    idle(2);
    check_harts("ipi_o", msip_shadow, ipi);

    // Timer interrupt of each hart in turn
    for (int h = 0; h < `NUM_HARTS; h++) begin
      cmp_addr = `CLINT_BASE + `MTIMECMP_OFS + 8 * h;
      read_mtime();
      idle(2);
      write_word(cmp_addr, 8'hff, last_mtime + 64'd3);
      read_word(cmp_addr);
      idle(2);
      wait_timer(h);
      read_mtime();
      write_word(cmp_addr, 8'hff, '1);
      idle(3);
      check_harts("timer_irq_o", '0, timer_irq);
    end

    // Debug-module reset clears the CLINT but not the DRAM
    write_word(`CLINT_BASE + `MTIMECMP_OFS + 8, 8'hff, 64'h0);
    idle(2);
    irq_exp    = '0;
    irq_exp[1] = 1'b1;
    check_harts("timer_irq_o", irq_exp, timer_irq);
    ndmreset = 1'b1;
    repeat (2) @(negedge clk);
    ndmreset    = 1'b0;
    msip_shadow = '0;
    last_mtime  = '0;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      cmp_shadow[h] = '1;
    end
    repeat (4) @(negedge clk);
    check_harts("ipi_o", '0, ipi);
    check_harts("timer_irq_o", '0, timer_irq);
    for (int h = 0; h < `NUM_HARTS; h++) begin
      read_word(`CLINT_BASE + 8 * h);
      read_word(`CLINT_BASE + `MTIMECMP_OFS + 8 * h);
    end
    read_mtime();
    for (int i = 0; i < `DRAM_WORDS; i++) begin
      if (dram_written[i]) begin
        read_word(`DRAM_BASE + 8 * i);
      end
    end
    idle(2);

    n = 0;
    while (exp_q.size() != 0) begin
      if (n == Timeout) begin
        abort_run("bus responses were still outstanding at the end of the run");
      end
      @(negedge clk);
      n++;
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
